// File: Bender.yml
package:
  name: i3c_ctrl

sources:
  - include_dirs:
      - .
    files:
      - i3c_pkg.sv
      - i3c_ifs.sv
      - hci_queue.sv
      - csr_axil.sv
      - cmd_decode.sv
      - bus_execute.sv
      - resp_build.sv
      - i3c_top.sv
      - target: test
        files:
          - tb_i3c.sv

// File: bus_execute.sv
// Legacy I2C bus transfer engine
`timescale 1ns/1ps
`include "i3c_params.svh"

module bus_execute (
  input  logic  clk_i,
  input  logic  rst_n_i,
  cmd_if.dst    cmd,
  result_if.src res,
  input  logic  pending_i,
  output logic  busy_o,
  input  logic  scl_i,
  input  logic  sda_i,
  output logic  scl_oe_o,
  output logic  sda_oe_o
);
  localparam int unsigned CNT_W = (`SCL_HALF > 1) ? $clog2(`SCL_HALF) : 1;

  i3c_pkg::bus_state_e state_q;
  i3c_pkg::cmd_op_e    op_q;
  i3c_pkg::byte_t      rx_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                phase_q;
  logic [2:0]          bit_q;
  logic [15:0]         shift_q;
  logic                accept;
  logic                on_wire;
  logic                tick;
  logic                bit_end;
  logic                sda_s;
  logic                scl_want;
  logic                sda_want;
  logic                sda_hold;

  assign cmd.ready = (state_q == i3c_pkg::IDLE);
  assign accept    = cmd.valid && cmd.ready;
  assign busy_o    = (state_q != i3c_pkg::IDLE) || pending_i;

  // States that clock SCL
  assign on_wire = state_q inside {i3c_pkg::ADDR, i3c_pkg::ADDR_ACK, i3c_pkg::DATA,
                                   i3c_pkg::DATA_ACK, i3c_pkg::STOP};

  // Phase 0 is SCL low, phase 1 is SCL high
  assign tick     = (cnt_q == CNT_W'(`SCL_HALF - 1));
  assign bit_end  = tick && phase_q;
  assign scl_want = on_wire && !phase_q;
  // SDA moves one cycle after SCL falls
  assign sda_hold = on_wire && !phase_q && (cnt_q == '0);
  // Line counts as released unless SCL is seen high
  assign sda_s    = sda_i || !scl_i;

  always_comb begin
    case (state_q)
      i3c_pkg::START: sda_want = phase_q;
      i3c_pkg::ADDR:  sda_want = !shift_q[15];
      i3c_pkg::DATA:  sda_want = (op_q == i3c_pkg::OP_WRITE) && !shift_q[15];
      i3c_pkg::STOP:  sda_want = 1'b1;
      default:        sda_want = 1'b0;
    endcase
  end

  // Registered pull-low enables
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_oe_o <= 1'b0;
      sda_oe_o <= 1'b0;
    end else begin
      scl_oe_o <= scl_want;
      if (!sda_hold) begin
        sda_oe_o <= sda_want;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= i3c_pkg::IDLE;
      cnt_q     <= '0;
      phase_q   <= 1'b0;
      bit_q     <= '0;
      res.valid <= 1'b0;
    end else begin
      if ((state_q inside {i3c_pkg::IDLE, i3c_pkg::REPORT}) || tick) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (tick) begin
        phase_q <= !phase_q;
      end
      case (state_q)
        i3c_pkg::IDLE: begin
          if (accept && (cmd.op == i3c_pkg::OP_BAD)) begin
            state_q   <= i3c_pkg::REPORT;
            res.valid <= 1'b1;
          end else if (accept) begin
            state_q <= i3c_pkg::START;
          end
        end
        i3c_pkg::START: begin
          if (bit_end) begin
            state_q <= i3c_pkg::ADDR;
          end
        end
        i3c_pkg::ADDR, i3c_pkg::DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= (state_q == i3c_pkg::ADDR) ? i3c_pkg::ADDR_ACK : i3c_pkg::DATA_ACK;
            end
          end
        end
        i3c_pkg::ADDR_ACK: begin
          // Address NACK skips the data phase
          if (bit_end) begin
            state_q <= sda_s ? i3c_pkg::STOP : i3c_pkg::DATA;
          end
        end
        i3c_pkg::DATA_ACK: begin
          if (bit_end) begin
            state_q <= i3c_pkg::STOP;
          end
        end
        i3c_pkg::STOP: begin
          if (bit_end) begin
            state_q   <= i3c_pkg::REPORT;
            res.valid <= 1'b1;
          end
        end
        default: begin
          if (res.ready) begin
            state_q   <= i3c_pkg::IDLE;
            res.valid <= 1'b0;
          end
        end
      endcase
    end
  end

  // Transfer payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q       <= cmd.op;
      shift_q    <= {cmd.addr, cmd.op == i3c_pkg::OP_READ, cmd.data};
      rx_q       <= '0;
      res.tid    <= cmd.tid;
      res.data   <= '0;
      res.status <= (cmd.op == i3c_pkg::OP_BAD) ? i3c_pkg::RESP_BAD_OP : i3c_pkg::RESP_OK;
    end
    if (bit_end && (state_q inside {i3c_pkg::ADDR, i3c_pkg::DATA})) begin
      shift_q <= {shift_q[14:0], 1'b0};
    end
    if (bit_end && (state_q == i3c_pkg::DATA) && (op_q == i3c_pkg::OP_READ)) begin
      rx_q <= {rx_q[6:0], sda_s};
    end
    if (bit_end && (state_q == i3c_pkg::ADDR_ACK) && sda_s) begin
      res.status <= i3c_pkg::RESP_NACK;
    end
    if (bit_end && (state_q == i3c_pkg::STOP)) begin
      res.data <= rx_q;
    end
  end

endmodule

// File: cmd_decode.sv
// Command descriptor decoder
`timescale 1ns/1ps
`include "i3c_params.svh"

module cmd_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   enable_i,
  input  logic                   pop_valid_i,
  output logic                   pop_ready_o,
  input  logic [`I3C_DATA_W-1:0] pop_data_i,
  cmd_if.src                     cmd,
  output logic                   pending_o
);
  logic             pop_fire;
  i3c_pkg::cmd_op_e op_dec;

  // Pop when the holding register is free or handing off
  assign pop_ready_o = enable_i && (!cmd.valid || cmd.ready);
  assign pop_fire    = pop_valid_i && pop_ready_o;
  assign pending_o   = cmd.valid;

  always_comb begin
    case (pop_data_i[5:4])
      2'd0:    op_dec = i3c_pkg::OP_WRITE;
      2'd1:    op_dec = i3c_pkg::OP_READ;
      default: op_dec = i3c_pkg::OP_BAD;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd.valid <= 1'b0;
    end else if (pop_fire) begin
      cmd.valid <= 1'b1;
    end else if (cmd.ready) begin
      cmd.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      cmd.op   <= op_dec;
      cmd.tid  <= pop_data_i[3:0];
      cmd.addr <= pop_data_i[14:8];
      cmd.data <= pop_data_i[23:16];
    end
  end

endmodule

// File: csr_axil.sv
// AXI4-Lite register block
`timescale 1ns/1ps
`include "i3c_params.svh"

module csr_axil (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [`I3C_ADDR_W-1:0]            s_axil_awaddr_i,
  input  logic                              s_axil_awvalid_i,
  output logic                              s_axil_awready_o,
  input  logic [`I3C_DATA_W-1:0]            s_axil_wdata_i,
  input  logic [`I3C_DATA_W/8-1:0]          s_axil_wstrb_i,
  input  logic                              s_axil_wvalid_i,
  output logic                              s_axil_wready_o,
  output logic [1:0]                        s_axil_bresp_o,
  output logic                              s_axil_bvalid_o,
  input  logic                              s_axil_bready_i,
  input  logic [`I3C_ADDR_W-1:0]            s_axil_araddr_i,
  input  logic                              s_axil_arvalid_i,
  output logic                              s_axil_arready_o,
  output logic [`I3C_DATA_W-1:0]            s_axil_rdata_o,
  output logic [1:0]                        s_axil_rresp_o,
  output logic                              s_axil_rvalid_o,
  input  logic                              s_axil_rready_i,
  output logic                              cmd_push_valid_o,
  input  logic                              cmd_push_ready_i,
  output logic [`I3C_DATA_W-1:0]            cmd_push_data_o,
  input  logic                              resp_pop_valid_i,
  output logic                              resp_pop_ready_o,
  input  logic [`I3C_DATA_W-1:0]            resp_pop_data_i,
  input  logic [$clog2(`CMD_DEPTH+1)-1:0]   cmd_level_i,
  input  logic [$clog2(`RESP_DEPTH+1)-1:0]  resp_level_i,
  input  logic                              exec_busy_i,
  output logic                              enable_o,
  output logic                              idle_o
);
  localparam logic [1:0] AXI_OKAY   = 2'b00;
  localparam logic [1:0] AXI_SLVERR = 2'b10;

  logic                   wr_fire;
  logic                   rd_fire;
  logic [`I3C_DATA_W-1:0] status_w;

  // Address and data taken together, one write in flight
  assign wr_fire          = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
  assign s_axil_awready_o = wr_fire;
  assign s_axil_wready_o  = wr_fire;

  assign s_axil_arready_o = !s_axil_rvalid_o;
  assign rd_fire          = s_axil_arvalid_i && s_axil_arready_o;

  // Queue port access
  assign cmd_push_valid_o = wr_fire && (s_axil_awaddr_i == `REG_CMD_PORT);
  assign cmd_push_data_o  = s_axil_wdata_i;
  assign resp_pop_ready_o = rd_fire && (s_axil_araddr_i == `REG_RESP_PORT);

  assign idle_o   = (cmd_level_i == '0) && !exec_busy_i;
  assign status_w = {23'd0, idle_o, 1'b0, 3'(resp_level_i), 1'b0, 3'(cmd_level_i)};

  // Write channel and CONTROL register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_axil_bvalid_o <= 1'b0;
      enable_o        <= 1'b0;
    end else if (wr_fire) begin
      s_axil_bvalid_o <= 1'b1;
      if ((s_axil_awaddr_i == `REG_CONTROL) && s_axil_wstrb_i[0]) begin
        enable_o <= s_axil_wdata_i[0];
      end
    end else if (s_axil_bready_i) begin
      s_axil_bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      case (s_axil_awaddr_i)
        `REG_CONTROL:  s_axil_bresp_o <= AXI_OKAY;
        // Full queue drops the push
        `REG_CMD_PORT: s_axil_bresp_o <= cmd_push_ready_i ? AXI_OKAY : AXI_SLVERR;
        default:       s_axil_bresp_o <= AXI_SLVERR;
      endcase
    end
  end

  // Read channel
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_axil_rvalid_o <= 1'b0;
    end else if (rd_fire) begin
      s_axil_rvalid_o <= 1'b1;
    end else if (s_axil_rready_i) begin
      s_axil_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      s_axil_rdata_o <= '0;
      s_axil_rresp_o <= AXI_SLVERR;
      case (s_axil_araddr_i)
        `REG_CONTROL: begin
          s_axil_rdata_o <= {31'd0, enable_o};
          s_axil_rresp_o <= AXI_OKAY;
        end
        `REG_STATUS: begin
          s_axil_rdata_o <= status_w;
          s_axil_rresp_o <= AXI_OKAY;
        end
        `REG_RESP_PORT: begin
          // Empty queue leaves SLVERR and zero data
          if (resp_pop_valid_i) begin
            s_axil_rdata_o <= resp_pop_data_i;
            s_axil_rresp_o <= AXI_OKAY;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: hci_queue.sv
// Descriptor FIFO
`timescale 1ns/1ps
`include "i3c_params.svh"

module hci_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       push_valid_i,
  output logic                       push_ready_o,
  input  logic [`I3C_DATA_W-1:0]     push_data_i,
  output logic                       pop_valid_o,
  input  logic                       pop_ready_i,
  output logic [`I3C_DATA_W-1:0]     pop_data_o,
  output logic [$clog2(DEPTH+1)-1:0] level_o
);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [`I3C_DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   push_fire;
  logic                   pop_fire;

  // Pointer advance with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign push_fire    = push_valid_i && push_ready_o;
  assign pop_fire     = pop_valid_o && pop_ready_i;
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign level_o      = count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_fire) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push_fire && !pop_fire) begin
        count_q <= count_q + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: i3c_ifs.sv
// Core pipeline handshake interfaces
`timescale 1ns/1ps

// Decoded command from decode to execute
interface cmd_if;
  logic                valid;
  logic                ready;
  i3c_pkg::cmd_op_e    op;
  i3c_pkg::tgt_addr_t  addr;
  i3c_pkg::byte_t      data;
  i3c_pkg::tid_t       tid;

  modport src (
    output valid, op, addr, data, tid,
    input  ready
  );

  modport dst (
    input  valid, op, addr, data, tid,
    output ready
  );
endinterface

// Transfer result from execute to response builder
interface result_if;
  logic                  valid;
  logic                  ready;
  i3c_pkg::tid_t         tid;
  i3c_pkg::resp_status_e status;
  i3c_pkg::byte_t        data;

  modport src (
    output valid, tid, status, data,
    input  ready
  );

  modport dst (
    input  valid, tid, status, data,
    output ready
  );
endinterface

// File: i3c_params.svh
// I3C controller parameters
`ifndef I3C_PARAMS_SVH
`define I3C_PARAMS_SVH

// Register and descriptor width
`define I3C_DATA_W 32
`define I3C_ADDR_W 4

// Queue depths
`define CMD_DEPTH 4
`define RESP_DEPTH 4

// Clock cycles per SCL half-period
`define SCL_HALF 4

// Register offsets
`define REG_CONTROL 4'h0
`define REG_STATUS 4'h4
`define REG_CMD_PORT 4'h8
`define REG_RESP_PORT 4'hC

`endif

// File: i3c_pkg.sv
// I3C controller types
package i3c_pkg;

  // Decoded command opcode
  typedef enum logic [1:0] {
    OP_WRITE = 2'd0,
    OP_READ  = 2'd1,
    OP_BAD   = 2'd2
  } cmd_op_e;

  // Response status field
  typedef enum logic [1:0] {
    RESP_OK     = 2'd0,
    RESP_NACK   = 2'd1,
    RESP_BAD_OP = 2'd2
  } resp_status_e;

  // Bus transfer states
  typedef enum logic [2:0] {
    IDLE,
    START,
    ADDR,
    ADDR_ACK,
    DATA,
    DATA_ACK,
    STOP,
    REPORT
  } bus_state_e;

  // Descriptor fields
  typedef logic [3:0] tid_t;
  typedef logic [6:0] tgt_addr_t;
  typedef logic [7:0] byte_t;

endpackage

// File: i3c_top.sv
// I2C controller top level
`timescale 1ns/1ps
`include "i3c_params.svh"

module i3c_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`I3C_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  logic [`I3C_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`I3C_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  input  logic [`I3C_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [`I3C_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i,
  input  logic                     scl_i,
  input  logic                     sda_i,
  output logic                     scl_oe_o,
  output logic                     sda_oe_o,
  output logic                     idle_o
);
  // Command queue
  logic                              cmd_push_valid;
  logic                              cmd_push_ready;
  logic [`I3C_DATA_W-1:0]            cmd_push_data;
  logic                              cmd_pop_valid;
  logic                              cmd_pop_ready;
  logic [`I3C_DATA_W-1:0]            cmd_pop_data;
  logic [$clog2(`CMD_DEPTH+1)-1:0]   cmd_level;

  // Response queue
  logic                              resp_push_valid;
  logic                              resp_push_ready;
  logic [`I3C_DATA_W-1:0]            resp_push_data;
  logic                              resp_pop_valid;
  logic                              resp_pop_ready;
  logic [`I3C_DATA_W-1:0]            resp_pop_data;
  logic [$clog2(`RESP_DEPTH+1)-1:0]  resp_level;

  logic                              enable;
  logic                              pending;
  logic                              exec_busy;

  cmd_if    cmd_bus ();
  result_if res_bus ();

  // AXI4-Lite and idle ports connect by name
  csr_axil u_csr (
    .*,
    .cmd_push_valid_o (cmd_push_valid),
    .cmd_push_ready_i (cmd_push_ready),
    .cmd_push_data_o  (cmd_push_data),
    .resp_pop_valid_i (resp_pop_valid),
    .resp_pop_ready_o (resp_pop_ready),
    .resp_pop_data_i  (resp_pop_data),
    .cmd_level_i      (cmd_level),
    .resp_level_i     (resp_level),
    .exec_busy_i      (exec_busy),
    .enable_o         (enable)
  );

  hci_queue #(.DEPTH(`CMD_DEPTH)) cmd_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (cmd_push_valid),
    .push_ready_o (cmd_push_ready),
    .push_data_i  (cmd_push_data),
    .pop_valid_o  (cmd_pop_valid),
    .pop_ready_i  (cmd_pop_ready),
    .pop_data_o   (cmd_pop_data),
    .level_o      (cmd_level)
  );

  cmd_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .enable_i    (enable),
    .pop_valid_i (cmd_pop_valid),
    .pop_ready_o (cmd_pop_ready),
    .pop_data_i  (cmd_pop_data),
    .cmd         (cmd_bus.src),
    .pending_o   (pending)
  );

  bus_execute u_exec (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cmd       (cmd_bus.dst),
    .res       (res_bus.src),
    .pending_i (pending),
    .busy_o    (exec_busy),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .scl_oe_o  (scl_oe_o),
    .sda_oe_o  (sda_oe_o)
  );

  resp_build u_resp (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .res          (res_bus.dst),
    .push_valid_o (resp_push_valid),
    .push_ready_i (resp_push_ready),
    .push_data_o  (resp_push_data)
  );

  hci_queue #(.DEPTH(`RESP_DEPTH)) resp_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (resp_push_valid),
    .push_ready_o (resp_push_ready),
    .push_data_i  (resp_push_data),
    .pop_valid_o  (resp_pop_valid),
    .pop_ready_i  (resp_pop_ready),
    .pop_data_o   (resp_pop_data),
    .level_o      (resp_level)
  );

endmodule

// File: resp_build.sv
// Response descriptor builder
`timescale 1ns/1ps
`include "i3c_params.svh"

module resp_build (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  result_if.dst                  res,
  output logic                   push_valid_o,
  input  logic                   push_ready_i,
  output logic [`I3C_DATA_W-1:0] push_data_o
);
  // One word held until the queue takes it
  assign res.ready = !push_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      push_valid_o <= 1'b0;
    end else if (res.valid && res.ready) begin
      push_valid_o <= 1'b1;
    end else if (push_ready_i) begin
      push_valid_o <= 1'b0;
    end
  end

  // Layout is data in 23:16, status in 5:4, tid in 3:0
  always_ff @(posedge clk_i) begin
    if (res.valid && res.ready) begin
      push_data_o <= {8'd0, res.data, 10'd0, res.status, res.tid};
    end
  end

endmodule

// File: tb_i3c.sv
// I2C controller testbench
`timescale 1ns/1ps
`include "i3c_params.svh"

module tb_i3c;
  // Nine bus transfers of about 170 cycles, polling and register traffic, with margin
  localparam int MAX_CYCLES = 6000;
  localparam logic [6:0] TGT_ADDR = 7'h50;

  logic        clk_i;
  logic        rst_n_i;
  logic [3:0]  s_axil_awaddr_i;
  logic        s_axil_awvalid_i;
  logic        s_axil_awready_o;
  logic [31:0] s_axil_wdata_i;
  logic [3:0]  s_axil_wstrb_i;
  logic        s_axil_wvalid_i;
  logic        s_axil_wready_o;
  logic [1:0]  s_axil_bresp_o;
  logic        s_axil_bvalid_o;
  logic        s_axil_bready_i;
  logic [3:0]  s_axil_araddr_i;
  logic        s_axil_arvalid_i;
  logic        s_axil_arready_o;
  logic [31:0] s_axil_rdata_o;
  logic [1:0]  s_axil_rresp_o;
  logic        s_axil_rvalid_o;
  logic        s_axil_rready_i;
  logic        scl_oe_o;
  logic        sda_oe_o;
  logic        idle_o;
  wire         scl_i;
  wire         sda_i;

  // Target model state
  logic        tgt_sda_low;
  logic        tgt_active;
  logic        tgt_sel;
  logic        tgt_rd;
  logic [7:0]  tgt_shift;
  logic [7:0]  tgt_tx;
  int          tgt_cnt;
  int          tgt_stops;
  int          tgt_wr_count;

  // Expected responses, tid in 3:0, status in 5:4, read data flag in 6
  logic [7:0]  exp_resp[$];
  logic [7:0]  exp_wr[$];
  logic [7:0]  rd_bytes[$];

  int          errors;
  int          checks;
  int          cycles;
  int          scl_falls;
  int          falls_before;
  int          stops_before;
  logic        scl_q;
  logic [31:0] rnd;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic [1:0]  wr_resp;
  logic [3:0]  tid;

  // Open-drain lines with pull-ups
  assign scl_i = !scl_oe_o;
  assign sda_i = !(sda_oe_o || tgt_sda_low);

  i3c_top dut0 (.*);

  always #4 clk_i = ~clk_i;

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("** Error: %s", msg);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk_i);
    s_axil_awaddr_i  <= addr;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wdata_i   <= data;
    s_axil_wvalid_i  <= 1'b1;
    s_axil_bready_i  <= 1'b1;
    @(posedge clk_i);
    while (!s_axil_awready_o) @(posedge clk_i);
    // Address and data are taken in the same cycle
    expect_value("s_axil_wready_o", s_axil_wready_o, 1'b1);
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
    @(posedge clk_i);
    while (!s_axil_bvalid_o) @(posedge clk_i);
    resp = s_axil_bresp_o;
    s_axil_bready_i <= 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk_i);
    s_axil_araddr_i  <= addr;
    s_axil_arvalid_i <= 1'b1;
    s_axil_rready_i  <= 1'b1;
    @(posedge clk_i);
    while (!s_axil_arready_o) @(posedge clk_i);
    s_axil_arvalid_i <= 1'b0;
    @(posedge clk_i);
    while (!s_axil_rvalid_o) @(posedge clk_i);
    data = s_axil_rdata_o;
    resp = s_axil_rresp_o;
    s_axil_rready_i <= 1'b0;
  endtask

  // Queue one descriptor and record its expected outcome
  task automatic send_cmd(input logic [3:0] t, input logic [1:0] op,
                          input logic [6:0] addr, input logic [7:0] wbyte);
    logic [1:0] status;
    logic [1:0] resp;
    if (op[1]) status = i3c_pkg::RESP_BAD_OP;
    else if (addr != TGT_ADDR) status = i3c_pkg::RESP_NACK;
    else status = i3c_pkg::RESP_OK;
    exp_resp.push_back({1'b0, (status == i3c_pkg::RESP_OK) && (op == 2'd1), status, t});
    if ((status == i3c_pkg::RESP_OK) && (op == 2'd0)) exp_wr.push_back(wbyte);
    write_reg(`REG_CMD_PORT, {8'd0, wbyte, 1'b0, addr, 2'b00, op, t}, resp);
    expect_value("s_axil_bresp_o", resp, 2'b00);
  endtask

  task automatic wait_resp_level(input int n);
    logic [31:0] data;
    logic [1:0]  resp;
    data = '0;
    while (data[6:4] < n) read_reg(`REG_STATUS, data, resp);
  endtask

  // Pop the next response and compare it with the oldest expectation
  task automatic check_resp();
    logic [7:0]  exp;
    logic [7:0]  exp_data;
    logic [31:0] data;
    logic [1:0]  resp;
    exp_data = 8'd0;
    if (exp_resp.size() == 0) begin
      report_failure("response read with no command outstanding");
      return;
    end
    exp = exp_resp.pop_front();
    wait_resp_level(1);
    if (exp[6] && (rd_bytes.size() == 0)) report_failure("target drove no byte for a read");
    else if (exp[6]) exp_data = rd_bytes.pop_front();
    read_reg(`REG_RESP_PORT, data, resp);
    expect_value("s_axil_rresp_o", resp, 2'b00);
    expect_value("s_axil_rdata_o", data, {8'd0, exp_data, 10'd0, exp[5:4], exp[3:0]});
  endtask

  // START resets the frame, STOP closes it
  always @(negedge sda_i) begin
    if ((rst_n_i === 1'b1) && (scl_i === 1'b1)) begin
      tgt_active = 1'b1;
      tgt_sel    = 1'b0;
      tgt_cnt    = 0;
    end
  end

  always @(posedge sda_i) begin
    if ((scl_i === 1'b1) && tgt_active) begin
      // Nine bits and STOP when not addressed, eighteen and STOP otherwise
      expect_value("target SCL rise count", tgt_cnt, tgt_sel ? 19 : 10);
      tgt_active = 1'b0;
      tgt_stops++;
    end
  end

  always @(posedge scl_i) begin
    if (tgt_active) begin
      tgt_cnt++;
      if ((tgt_cnt <= 8) || ((tgt_cnt >= 10) && (tgt_cnt <= 17))) begin
        tgt_shift = {tgt_shift[6:0], sda_i};
      end
      if (tgt_cnt == 8) begin
        tgt_sel = (tgt_shift[7:1] == TGT_ADDR);
        tgt_rd  = tgt_shift[0];
        if (tgt_sel && tgt_rd) begin
          rnd    = $urandom;
          tgt_tx = rnd[7:0];
          rd_bytes.push_back(rnd[7:0]);
        end
      end
      if ((tgt_cnt == 17) && tgt_sel && !tgt_rd) begin
        tgt_wr_count++;
        if (exp_wr.size() == 0) report_failure("target captured a byte no command wrote");
        else expect_value("target write byte", tgt_shift, exp_wr.pop_front());
      end
    end
  end

  // Target drives SDA only while SCL is low
  always @(negedge scl_i) begin
    if (tgt_active) begin
      tgt_sda_low = 1'b0;
      if (tgt_sel && (tgt_cnt == 8)) begin
        tgt_sda_low = 1'b1;
      end else if (tgt_sel && tgt_rd && (tgt_cnt >= 9) && (tgt_cnt <= 16)) begin
        tgt_sda_low = !tgt_tx[7];
        tgt_tx      = {tgt_tx[6:0], 1'b0};
      end else if (tgt_sel && !tgt_rd && (tgt_cnt == 17)) begin
        tgt_sda_low = 1'b1;
      end
    end
  end

  // SCL falls only inside a frame
  always @(posedge clk_i) begin
    if ((rst_n_i === 1'b1) && scl_q && !scl_i) begin
      scl_falls++;
      assert (tgt_active) else report_failure("SCL fell outside a START to STOP frame");
    end
    scl_q = scl_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Summary: %0d checks, %0d errors", checks, errors + 1);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rnd = $urandom(32'h8041f79e);
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    s_axil_awaddr_i = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i = '0;
    s_axil_wstrb_i = 4'hF;
    s_axil_wvalid_i = 1'b0;
    s_axil_bready_i = 1'b0;
    s_axil_araddr_i = '0;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i = 1'b0;
    tgt_sda_low = 1'b0;
    tgt_active = 1'b0;
    tgt_sel = 1'b0;
    tgt_rd = 1'b0;
    tgt_cnt = 0;
    tgt_stops = 0;
    tgt_wr_count = 0;
    errors = 0;
    checks = 0;
    cycles = 0;
    scl_falls = 0;
    scl_q = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    // Reset state
    expect_value("s_axil_bvalid_o", s_axil_bvalid_o, 1'b0);
    expect_value("s_axil_rvalid_o", s_axil_rvalid_o, 1'b0);
    expect_value("scl_oe_o", scl_oe_o, 1'b0);
    expect_value("sda_oe_o", sda_oe_o, 1'b0);
    expect_value("idle_o", idle_o, 1'b1);
    read_reg(`REG_CONTROL, rd_data, rd_resp);
    expect_value("CONTROL", rd_data, 32'h0);

    // Registers and error responses
    write_reg(`REG_CONTROL, 32'h1, wr_resp);
    read_reg(`REG_CONTROL, rd_data, rd_resp);
    expect_value("CONTROL", rd_data, 32'h1);
    write_reg(`REG_CONTROL, 32'h0, wr_resp);
    read_reg(4'h2, rd_data, rd_resp);
    expect_value("s_axil_rresp_o", rd_resp, 2'b10);
    expect_value("s_axil_rdata_o", rd_data, 32'h0);
    read_reg(`REG_CMD_PORT, rd_data, rd_resp);
    expect_value("s_axil_rresp_o", rd_resp, 2'b10);
    expect_value("s_axil_rdata_o", rd_data, 32'h0);
    write_reg(`REG_STATUS, 32'h1, wr_resp);
    expect_value("s_axil_bresp_o", wr_resp, 2'b10);
    read_reg(`REG_RESP_PORT, rd_data, rd_resp);
    expect_value("s_axil_rresp_o", rd_resp, 2'b10);
    expect_value("s_axil_rdata_o", rd_data, 32'h0);

    // Write, absent address and read, held while disabled
    rnd = $urandom;
    send_cmd(4'd1, 2'd0, TGT_ADDR, rnd[7:0]);
    send_cmd(4'd2, 2'd0, 7'h23, rnd[15:8]);
    send_cmd(4'd3, 2'd1, TGT_ADDR, 8'h00);
    read_reg(`REG_STATUS, rd_data, rd_resp);
    expect_value("STATUS", rd_data, 32'h3);
    expect_value("idle_o", idle_o, 1'b0);
    expect_value("SCL falls", scl_falls, 0);
    expect_value("scl_i", scl_i, 1'b1);

    write_reg(`REG_CONTROL, 32'h1, wr_resp);
    repeat (3) check_resp();
    expect_value("target write count", tgt_wr_count, 1);

    // Bad opcode never touches the bus
    falls_before = scl_falls;
    send_cmd(4'd4, 2'd3, TGT_ADDR, 8'hA5);
    check_resp();
    expect_value("SCL falls", scl_falls, falls_before);

    // Six commands against an unread response queue
    stops_before = tgt_stops;
    for (tid = 4'd5; tid <= 4'd10; tid++) begin
      rnd = $urandom;
      send_cmd(tid, {1'b0, tid[0]}, (tid == 4'd8) ? 7'h21 : TGT_ADDR, rnd[7:0]);
    end
    while (tgt_stops < stops_before + 6) @(posedge clk_i);
    read_reg(`REG_STATUS, rd_data, rd_resp);
    expect_value("STATUS", rd_data, 32'h40);
    expect_value("idle_o", idle_o, 1'b0);
    repeat (6) check_resp();

    if (exp_resp.size() != 0) report_failure("responses missing at the end of the run");
    if (exp_wr.size() != 0) report_failure("target missed a written byte");
    if (rd_bytes.size() != 0) report_failure("read byte never returned in a response");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
i3c_pkg.sv
i3c_ifs.sv
hci_queue.sv
csr_axil.sv
cmd_decode.sv
bus_execute.sv
resp_build.sv
i3c_top.sv
tb_i3c.sv
